// ==== mrdma_pkg.sv ====
/*
  shared widths, field positions and encodings for the mrdma ingress
  command generator
*/
package mrdma_pkg;

  // ====================
  // address widths
  // ====================

  // byte bits dropped by the 8-byte address unit
  localparam int atom_shift  = 3;
  // full byte address sent to the dma
  localparam int dma_addr_w  = 32;
  // address in 8-byte units
  localparam int line_addr_w = dma_addr_w - atom_shift;

  // ====================
  // cube shape
  // ====================

  // channel, height and width registers
  localparam int dim_w      = 13;
  // channel-group count, one more bit than channel[12:3]
  localparam int surf_cnt_w = 11;
  // request size field
  localparam int size_w     = 15;

  // ====================
  // payload layouts
  // ====================

  // dma request: byte address low, size on top
  localparam int dma_pd_w = dma_addr_w + size_w;
  // queue entry: size[12:0] low, cube end at bit 13
  localparam int cq_pd_w  = 14;

  // perf counter
  localparam int stall_w = 32;

  // input precision encoding
  localparam logic [1:0] prec_int8 = 2'd0;

endpackage

// ==== mrdma_step_if.sv ====
/*
  walk step channel from the cube walker to the issue stage
*/
interface mrdma_step_if;
  import mrdma_pkg::*;

  // step handshake
  logic                   valid;
  logic                   ready;
  // step payload, held while valid and not taken
  logic [line_addr_w-1:0] addr;
  logic [size_w-1:0]      size;
  logic                   cube_end;

  // walker side produces steps
  modport walker (
    output valid, addr, size, cube_end,
    input  ready
  );

  // issue side consumes them
  modport issue (
    input  valid, addr, size, cube_end,
    output ready
  );

endinterface

// ==== mrdma_cube_walker.sv ====
/*
  cube walker: busy flag, channel-group and line counters,
  line and surface base addresses, per-step size and cube end
*/
module mrdma_cube_walker (
  input  logic                              nvdla_core_clk,
  input  logic                              nvdla_core_rstn,
  input  logic                              op_load,
  input  logic [1:0]                        in_precision,
  input  logic [mrdma_pkg::dim_w-1:0]       channel,
  input  logic [mrdma_pkg::dim_w-1:0]       height,
  input  logic [mrdma_pkg::dim_w-1:0]       width,
  input  logic [mrdma_pkg::line_addr_w-1:0] base_addr,
  input  logic [mrdma_pkg::line_addr_w-1:0] line_stride,
  input  logic [mrdma_pkg::line_addr_w-1:0] surf_stride,
  mrdma_step_if.walker                      step
);
  import mrdma_pkg::*;

  logic                   busy;
  logic                   step_accept;
  logic                   mode_1x1_pack;
  logic [surf_cnt_w-1:0]  last_group;
  logic [surf_cnt_w-1:0]  count_c;
  logic [dim_w-1:0]       count_h;
  logic                   is_last_c;
  logic                   is_last_h;
  logic                   is_surf_end;
  logic                   is_cube_end;
  logic [line_addr_w-1:0] base_addr_line;
  logic [line_addr_w-1:0] base_addr_surf;

  // ====================
  // config decode
  // ====================

  // 1x1 pack, a single request covers the whole cube
  assign mode_1x1_pack = (width == '0) && (height == '0);

  // groups minus one: 8 channels per group at int8, 4 otherwise
  assign last_group = (in_precision == prec_int8) ?
                      {1'b0, channel[dim_w-1:3]} : channel[dim_w-1:2];

  // ====================
  // busy and handshake
  // ====================

  assign step_accept = step.valid & step.ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      busy <= 1'b0;
    end else if (op_load) begin
      busy <= 1'b1;
    end else if (step_accept && is_cube_end) begin
      // last step gone, idle next cycle
      busy <= 1'b0;
    end
  end

  // ====================
  // walk position
  // ====================

  assign is_last_c   = (count_c == last_group);
  assign is_last_h   = (count_h == height);
  // every step ends a line, so surface end is only the height check
  assign is_surf_end = mode_1x1_pack | is_last_h;
  assign is_cube_end = is_surf_end & (mode_1x1_pack | is_last_c);

  // channel groups
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (step_accept) begin
      if (is_cube_end) begin
        count_c <= '0;
      end else if (is_surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // lines inside one group
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (step_accept) begin
      if (is_surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

  // ====================
  // base addresses
  // ====================

  // both reload at op_load, surface end restarts lines on the next group
  always_ff @(posedge nvdla_core_clk) begin
    if (op_load) begin
      base_addr_line <= base_addr;
      base_addr_surf <= base_addr;
    end else if (step_accept) begin
      if (is_surf_end) begin
        base_addr_line <= base_addr_surf + surf_stride;
        base_addr_surf <= base_addr_surf + surf_stride;
      end else begin
        base_addr_line <= base_addr_line + line_stride;
      end
    end
  end

  // ====================
  // step out
  // ====================

  assign step.valid    = busy;
  assign step.addr     = base_addr_line;
  assign step.cube_end = is_cube_end;

  // pack mode sends the group count, otherwise the line width
  assign step.size = mode_1x1_pack ?
                     {{(size_w - surf_cnt_w){1'b0}}, last_group} :
                     {{(size_w - dim_w){1'b0}}, width};

endmodule

// ==== mrdma_req_issue.sv ====
/*
  issue stage: one-entry step register, dma and queue payload packing,
  cross-gated valids with joint acceptance
*/
module mrdma_req_issue (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  input  logic                           dma_rd_req_rdy,
  input  logic                           ig2cq_prdy,
  mrdma_step_if.issue                    step,
  output logic                           dma_rd_req_vld,
  output logic [mrdma_pkg::dma_pd_w-1:0] dma_rd_req_pd,
  output logic                           ig2cq_pvld,
  output logic [mrdma_pkg::cq_pd_w-1:0]  ig2cq_pd
);
  import mrdma_pkg::*;

  logic                   full;
  logic                   step_accept;
  logic                   out_accept;
  logic [line_addr_w-1:0] addr_q;
  logic [size_w-1:0]      size_q;
  logic                   cube_end_q;
  logic [dma_addr_w-1:0]  byte_addr;

  // ====================
  // handshakes
  // ====================

  // both ports take the entry in the same cycle or not at all
  assign out_accept  = full & dma_rd_req_rdy & ig2cq_prdy;
  // take a new step when empty or draining now
  assign step.ready  = ~full | out_accept;
  assign step_accept = step.valid & step.ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      full <= 1'b0;
    end else if (step_accept) begin
      full <= 1'b1;
    end else if (out_accept) begin
      full <= 1'b0;
    end
  end

  // step payload
  always_ff @(posedge nvdla_core_clk) begin
    if (step_accept) begin
      addr_q     <= step.addr;
      size_q     <= step.size;
      cube_end_q <= step.cube_end;
    end
  end

  // ====================
  // port side
  // ====================

  // each valid waits on the other port's ready
  assign dma_rd_req_vld = full & ig2cq_prdy;
  assign ig2cq_pvld     = full & dma_rd_req_rdy;

  // 8-byte units back to a byte address
  assign byte_addr     = {addr_q, {atom_shift{1'b0}}};
  assign dma_rd_req_pd = {size_q, byte_addr};

  // queue keeps only the low size bits plus cube end
  assign ig2cq_pd = {cube_end_q, size_q[cq_pd_w-2:0]};

endmodule

// ==== mrdma_stall_counter.sv ====
/*
  dma request stall counter with enable and clear at op_load
*/
module mrdma_stall_counter (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          op_load,
  input  logic                          perf_dma_en,
  input  logic                          dma_rd_req_vld,
  input  logic                          dma_rd_req_rdy,
  output logic [mrdma_pkg::stall_w-1:0] dp2reg_mrdma_stall
);
  import mrdma_pkg::*;

  logic               cnt_en;
  logic               stall_inc;
  logic [stall_w-1:0] stall_cnt;

  // request offered but not taken
  assign stall_inc = dma_rd_req_vld & ~dma_rd_req_rdy;

  // enable sampled once per op
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_en <= 1'b0;
    end else if (op_load) begin
      cnt_en <= perf_dma_en;
    end
  end

  // wraps at full width, holds while disabled
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (op_load) begin
      stall_cnt <= '0;
    end else if (cnt_en && stall_inc) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  assign dp2reg_mrdma_stall = stall_cnt;

endmodule

// ==== mrdma_ig_top.sv ====
/*
  mrdma ingress command generator top: walker, issue stage
  and stall counter behind plain ports
*/
module mrdma_ig_top (
  input  logic                              nvdla_core_clk,
  input  logic                              nvdla_core_rstn,
  input  logic                              op_load,
  // configuration
  input  logic [1:0]                        reg2dp_in_precision,
  input  logic [mrdma_pkg::dim_w-1:0]       reg2dp_channel,
  input  logic [mrdma_pkg::dim_w-1:0]       reg2dp_height,
  input  logic [mrdma_pkg::dim_w-1:0]       reg2dp_width,
  input  logic [mrdma_pkg::line_addr_w-1:0] reg2dp_src_base_addr_low,
  input  logic [mrdma_pkg::line_addr_w-1:0] reg2dp_src_line_stride,
  input  logic [mrdma_pkg::line_addr_w-1:0] reg2dp_src_surface_stride,
  input  logic                              reg2dp_perf_dma_en,
  // dma read request
  output logic                              dma_rd_req_vld,
  input  logic                              dma_rd_req_rdy,
  output logic [mrdma_pkg::dma_pd_w-1:0]    dma_rd_req_pd,
  // context queue
  output logic                              ig2cq_pvld,
  input  logic                              ig2cq_prdy,
  output logic [mrdma_pkg::cq_pd_w-1:0]     ig2cq_pd,
  // perf
  output logic [mrdma_pkg::stall_w-1:0]     dp2reg_mrdma_stall
);

  // walker to issue stage
  mrdma_step_if step_if ();

  // ====================
  // stage 1, cube walk
  // ====================

  mrdma_cube_walker u_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .in_precision    (reg2dp_in_precision),
    .channel         (reg2dp_channel),
    .height          (reg2dp_height),
    .width           (reg2dp_width),
    .base_addr       (reg2dp_src_base_addr_low),
    .line_stride     (reg2dp_src_line_stride),
    .surf_stride     (reg2dp_src_surface_stride),
    .step            (step_if.walker)
  );

  // ====================
  // stage 2, issue
  // ====================

  mrdma_req_issue u_issue (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .ig2cq_prdy      (ig2cq_prdy),
    .step            (step_if.issue),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_pd   (dma_rd_req_pd),
    .ig2cq_pvld      (ig2cq_pvld),
    .ig2cq_pd        (ig2cq_pd)
  );

  // stalls seen on the dma port
  mrdma_stall_counter u_stall (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .op_load            (op_load),
    .perf_dma_en        (reg2dp_perf_dma_en),
    .dma_rd_req_vld     (dma_rd_req_vld),
    .dma_rd_req_rdy     (dma_rd_req_rdy),
    .dp2reg_mrdma_stall (dp2reg_mrdma_stall)
  );

endmodule

// ==== mrdma_ig_checker.sv ====
/*
  port protocol assertions for the ingress command generator top
*/
module mrdma_ig_checker (
  input logic                           nvdla_core_clk,
  input logic                           nvdla_core_rstn,
  input logic                           op_load,
  input logic                           dma_rd_req_vld,
  input logic                           dma_rd_req_rdy,
  input logic [mrdma_pkg::dma_pd_w-1:0] dma_rd_req_pd,
  input logic                           ig2cq_pvld,
  input logic                           ig2cq_prdy,
  input logic [mrdma_pkg::cq_pd_w-1:0]  ig2cq_pd
);
  timeunit 1ns;
  timeprecision 100ps;

  logic loaded;

  // set by the first op_load, never cleared
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      loaded <= 1'b0;
    end else if (op_load) begin
      loaded <= 1'b1;
    end
  end

  // dma and queue take the entry together
  joint_accept: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_rd_req_vld && dma_rd_req_rdy) == (ig2cq_pvld && ig2cq_prdy))
    else $error("dma and queue ports accepted separately");

  dma_pd_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_rd_req_vld && !dma_rd_req_rdy |=> $stable(dma_rd_req_pd))
    else $error("dma payload changed while waiting");

  cq_pd_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    ig2cq_pvld && !ig2cq_prdy |=> $stable(ig2cq_pd))
    else $error("queue payload changed while waiting");

  no_early_valid: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !loaded |-> !dma_rd_req_vld && !ig2cq_pvld)
    else $error("valid raised before the first op_load");

endmodule

bind mrdma_ig_top mrdma_ig_checker u_checker (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .op_load         (op_load),
  .dma_rd_req_vld  (dma_rd_req_vld),
  .dma_rd_req_rdy  (dma_rd_req_rdy),
  .dma_rd_req_pd   (dma_rd_req_pd),
  .ig2cq_pvld      (ig2cq_pvld),
  .ig2cq_prdy      (ig2cq_prdy),
  .ig2cq_pd        (ig2cq_pd)
);

// ==== tb_mrdma_ig.sv ====
/*
  mrdma ingress command generator testbench with clock, reset,
  stimulus, reference walk, payload compare and result report
*/
module tb_mrdma_ig;
  timeunit 1ns;
  timeprecision 100ps;
  import mrdma_pkg::*;

  // requests over all tests, sets the run limit
  localparam int total_reqs  = 8 + 16 + 1 + 18 + 16 + 16;
  localparam int max_cycles  = total_reqs * 4 + 200;
  localparam int idle_cycles = 8;

  logic                   nvdla_core_clk = 1'b0;
  logic                   nvdla_core_rstn;
  logic                   op_load;
  logic [1:0]             cfg_prec;
  logic [dim_w-1:0]       cfg_channel;
  logic [dim_w-1:0]       cfg_height;
  logic [dim_w-1:0]       cfg_width;
  logic [line_addr_w-1:0] cfg_base;
  logic [line_addr_w-1:0] cfg_line_stride;
  logic [line_addr_w-1:0] cfg_surf_stride;
  logic                   cfg_perf_en;
  logic                   dma_rd_req_vld;
  logic                   dma_rd_req_rdy;
  logic [dma_pd_w-1:0]    dma_rd_req_pd;
  logic                   ig2cq_pvld;
  logic                   ig2cq_prdy;
  logic [cq_pd_w-1:0]     ig2cq_pd;
  logic [stall_w-1:0]     dp2reg_mrdma_stall;

  // owned by the compare process
  int    acc_cnt    = 0;
  int    stall_seen = 0;
  int    load_cycle = 0;
  int    first_lat  = 0;
  logic  lat_armed  = 1'b0;
  // owned by the stimulus
  int    acc_base   = 0;
  int    exp_total  = 0;
  string test_name  = "none";
  int    err_cnt    = 0;
  int    n_pass     = 0;
  int    n_fail     = 0;
  int    cycle_cnt  = 0;

  always #2 nvdla_core_clk = ~nvdla_core_clk;

  mrdma_ig_top DUT (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .op_load                   (op_load),
    .reg2dp_in_precision       (cfg_prec),
    .reg2dp_channel            (cfg_channel),
    .reg2dp_height             (cfg_height),
    .reg2dp_width              (cfg_width),
    .reg2dp_src_base_addr_low  (cfg_base),
    .reg2dp_src_line_stride    (cfg_line_stride),
    .reg2dp_src_surface_stride (cfg_surf_stride),
    .reg2dp_perf_dma_en        (cfg_perf_en),
    .dma_rd_req_vld            (dma_rd_req_vld),
    .dma_rd_req_rdy            (dma_rd_req_rdy),
    .dma_rd_req_pd             (dma_rd_req_pd),
    .ig2cq_pvld                (ig2cq_pvld),
    .ig2cq_prdy                (ig2cq_prdy),
    .ig2cq_pd                  (ig2cq_pd),
    .dp2reg_mrdma_stall        (dp2reg_mrdma_stall)
  );

  task automatic check(input string name, input string what,
                       input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %0h, actual %0h", name, what, expected, actual);
      err_cnt++;
    end
  endtask

  // 8 channels per group at int8, 4 at any other precision
  function automatic int group_count(input logic [1:0] p, input logic [dim_w-1:0] ch);
    if (p == prec_int8) begin
      return int'(ch >> 3) + 1;
    end
    return int'(ch >> 2) + 1;
  endfunction

  // expected {queue payload, dma payload} of walk step idx
  function automatic logic [cq_pd_w+dma_pd_w-1:0] ref_step(
    input logic [1:0] p, input logic [dim_w-1:0] ch, input logic [dim_w-1:0] h,
    input logic [dim_w-1:0] w, input logic [line_addr_w-1:0] base,
    input logic [line_addr_w-1:0] ls, input logic [line_addr_w-1:0] ss, input int idx);
    int                     groups;
    int                     lines;
    logic [line_addr_w-1:0] addr;
    logic [size_w-1:0]      size;
    logic                   cube_end;
    groups = group_count(p, ch);
    lines  = int'(h) + 1;
    if (h == '0 && w == '0) begin
      // 1x1 pack sends one request sized by the group count
      addr     = base;
      size     = size_w'(groups - 1);
      cube_end = 1'b1;
    end else begin
      // groups outer, lines inner
      addr     = base + line_addr_w'(idx / lines) * ss + line_addr_w'(idx % lines) * ls;
      size     = size_w'(w);
      cube_end = (idx == groups * lines - 1);
    end
    return {cube_end, size[cq_pd_w-2:0], size, addr, {atom_shift{1'b0}}};
  endfunction

  // ====================
  // compare process
  // ====================
  always @(posedge nvdla_core_clk) begin
    int                          idx;
    logic [cq_pd_w+dma_pd_w-1:0] exp_pd;
    idx = acc_cnt - acc_base;
    // latency from the sampled op_load to the first offered request
    if (op_load) begin
      load_cycle <= cycle_cnt;
      lat_armed  <= 1'b1;
    end else if (lat_armed && dma_rd_req_vld) begin
      first_lat <= cycle_cnt - load_cycle;
      lat_armed <= 1'b0;
    end
    if (dma_rd_req_vld && !dma_rd_req_rdy) begin
      stall_seen <= stall_seen + 1;
    end
    // both ports take each request in the same cycle
    if ((dma_rd_req_vld && dma_rd_req_rdy) != (ig2cq_pvld && ig2cq_prdy)) begin
      $display("%s: dma and queue ports accepted in different cycles", test_name);
      err_cnt++;
    end
    if (dma_rd_req_vld && dma_rd_req_rdy && ig2cq_pvld && ig2cq_prdy) begin
      if (idx >= exp_total) begin
        $display("%s: request %0d was accepted after the last step", test_name, idx);
        err_cnt++;
      end else begin
        exp_pd = ref_step(cfg_prec, cfg_channel, cfg_height, cfg_width, cfg_base,
                          cfg_line_stride, cfg_surf_stride, idx);
        check(test_name, "dma payload", 64'(exp_pd[dma_pd_w-1:0]), 64'(dma_rd_req_pd));
        check(test_name, "queue payload", 64'(exp_pd[cq_pd_w+dma_pd_w-1:dma_pd_w]),
              64'(ig2cq_pd));
      end
      acc_cnt <= acc_cnt + 1;
    end
  end

  // run limit
  always @(posedge nvdla_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic report_test(input string name, input int errs_before, input int n_req);
    if (err_cnt == errs_before) begin
      n_pass++;
      $display("test %s passed, %0d requests", name, n_req);
    end else begin
      n_fail++;
      $display("test %s failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // one op from config to idle with random readies when use_bp is set
  task automatic run_test(input string name, input logic [1:0] p, input logic [dim_w-1:0] ch,
                          input logic [dim_w-1:0] h, input logic [dim_w-1:0] w,
                          input logic [line_addr_w-1:0] base, input logic use_bp,
                          input logic perf);
    int errs_before;
    int stall_before;
    int n_req;
    errs_before  = err_cnt;
    stall_before = stall_seen;
    n_req        = (h == '0 && w == '0) ? 1 : group_count(p, ch) * (int'(h) + 1);
    @(posedge nvdla_core_clk);
    test_name       <= name;
    exp_total       <= n_req;
    acc_base        <= acc_cnt;
    cfg_prec        <= p;
    cfg_channel     <= ch;
    cfg_height      <= h;
    cfg_width       <= w;
    cfg_base        <= base;
    cfg_line_stride <= 29'h00040;
    cfg_surf_stride <= 29'h01000;
    cfg_perf_en     <= perf;
    @(posedge nvdla_core_clk);
    op_load <= 1'b1;
    @(posedge nvdla_core_clk);
    op_load <= 1'b0;
    while (acc_cnt - acc_base < n_req) begin
      @(posedge nvdla_core_clk);
      if (use_bp) begin
        dma_rd_req_rdy <= ($urandom % 4) != 0;
        ig2cq_prdy     <= ($urandom % 4) != 0;
      end
    end
    dma_rd_req_rdy <= 1'b1;
    ig2cq_prdy     <= 1'b1;
    // nothing may follow the cube end
    repeat (idle_cycles) begin
      @(posedge nvdla_core_clk);
      check(name, "idle dma valid", 64'd0, 64'(dma_rd_req_vld));
      check(name, "idle queue valid", 64'd0, 64'(ig2cq_pvld));
    end
    if (!use_bp) begin
      check(name, "first valid latency", 64'd2, 64'(first_lat));
    end
    if (perf) begin
      check(name, "stall count", 64'(stall_seen - stall_before), 64'(dp2reg_mrdma_stall));
    end else begin
      check(name, "stall count", 64'd0, 64'(dp2reg_mrdma_stall));
    end
    report_test(name, errs_before, n_req);
  endtask

  // ====================
  // test sequence
  // ====================
  initial begin
    logic [31:0] rnd_base;
    int          errs_before;
    void'($urandom(30772));
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    cfg_prec        = 2'd0;
    cfg_channel     = '0;
    cfg_height      = '0;
    cfg_width       = '0;
    cfg_base        = '0;
    cfg_line_stride = '0;
    cfg_surf_stride = '0;
    cfg_perf_en     = 1'b0;
    dma_rd_req_rdy  = 1'b1;
    ig2cq_prdy      = 1'b1;
    repeat (16) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    repeat (2) @(posedge nvdla_core_clk);
    errs_before = err_cnt;
    check("reset_state", "dma valid", 64'd0, 64'(dma_rd_req_vld));
    check("reset_state", "queue valid", 64'd0, 64'(ig2cq_pvld));
    check("reset_state", "stall count", 64'd0, 64'(dp2reg_mrdma_stall));
    report_test("reset_state", errs_before, 0);
    // 15 means 16 channels, two int8 groups or four int16 groups
    run_test("int8_cube", 2'd0, 13'd15, 13'd3, 13'd20, 29'h00100, 1'b0, 1'b0);
    run_test("int16_cube", 2'd1, 13'd15, 13'd3, 13'd20, 29'h00100, 1'b0, 1'b0);
    run_test("pack_1x1", 2'd0, 13'd15, 13'd0, 13'd0, 29'h00200, 1'b0, 1'b0);
    rnd_base = $urandom;
    run_test("random_bp", 2'd1, 13'd23, 13'd2, 13'd37, rnd_base[line_addr_w-1:0], 1'b1, 1'b0);
    run_test("stall_en", 2'd1, 13'd15, 13'd3, 13'd20, 29'h00300, 1'b1, 1'b1);
    run_test("stall_dis", 2'd1, 13'd15, 13'd3, 13'd20, 29'h00300, 1'b1, 1'b0);
    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
mrdma_pkg.sv
mrdma_step_if.sv
mrdma_cube_walker.sv
mrdma_req_issue.sv
mrdma_stall_counter.sv
mrdma_ig_top.sv
mrdma_ig_checker.sv
tb_mrdma_ig.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the mrdma ingress testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mrdma_ig -f sources.f -o tb_mrdma_ig

# verdict comes from the printed result line
out=$(./obj_dir/tb_mrdma_ig) || true
echo "$out"
echo "$out" | grep -q "RESULT: PASS"
